/* files.f */
muldiv_pkg.sv
booth_multiplier.sv
restoring_divider.sv
muldiv_result_format.sv
muldiv_unit.sv
tb_muldiv.sv

/* run_sim.sh */
#!/bin/sh
# build and run the muldiv testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_muldiv -f files.f

./obj_dir/Vtb_muldiv | tee sim.log

if grep -q 'Test failures found' sim.log; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation finished without failures"
exit 0

/* tb_muldiv.sv */
`timescale 1ns/1ps

module tb_muldiv;
	import muldiv_pkg::*;

	// dut inputs
	logic    clk;
	logic    rst;
	logic    op_valid;
	logic    flush;
	funct3_t funct3;
	logic    word;
	xlen_t   src_a;
	xlen_t   src_b;

	// dut outputs
	logic    ready;
	logic    result_valid;
	xlen_t   result;

	// bookkeeping
	int          pass_count;
	int          fail_count;
	logic        timed_out;
	logic [31:0] lcg_state;

	// directed table with one entry per row
	string   t_name[$];
	funct3_t t_f3[$];
	logic    t_word[$];
	xlen_t   t_a[$];
	xlen_t   t_b[$];
	xlen_t   t_exp[$];

	muldiv_unit u_muldiv_unit (
		.clk          (clk),
		.rst          (rst),
		.op_valid     (op_valid),
		.flush        (flush),
		.funct3       (funct3),
		.word         (word),
		.src_a        (src_a),
		.src_b        (src_b),
		.ready        (ready),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected value straight from the m-extension rules
	function automatic xlen_t ref_result(input funct3_t f3, input logic w, input xlen_t a,
			input xlen_t b);
		logic [127:0]       pa;
		logic [127:0]       pb;
		logic [127:0]       prod;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] sq;
		logic signed [31:0] wa;
		logic signed [31:0] wb;
		logic signed [31:0] wq;
		logic               is_signed;
		logic               is_rem;
		logic               zero;
		logic               ovf;
		xlen_t              r;
		if (!f3[2]) begin
			// 128-bit product where the extension picks the signedness
			pa = (f3 == F3_MULH || f3 == F3_MULHSU) ? {{64{a[63]}}, a} : {64'd0, a};
			pb = (f3 == F3_MULH) ? {{64{b[63]}}, b} : {64'd0, b};
			prod = pa * pb;
			r = (f3 == F3_MUL) ? prod[63:0] : prod[127:64];
		end else begin
			is_signed = !f3[0];
			is_rem = f3[1];
			zero = w ? (b[31:0] == 32'd0) : (b == 64'd0);
			ovf = is_signed && (w ?
				(a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) :
				(a == 64'h8000_0000_0000_0000 && b == 64'hffff_ffff_ffff_ffff));
			if (zero) begin
				r = is_rem ? a : 64'hffff_ffff_ffff_ffff;
			end else if (ovf) begin
				r = is_rem ? 64'd0 : a;
			end else if (w && is_signed) begin
				wa = a[31:0];
				wb = b[31:0];
				wq = is_rem ? wa % wb : wa / wb;
				r = {32'd0, wq};
			end else if (w) begin
				r = is_rem ? {32'd0, a[31:0] % b[31:0]} : {32'd0, a[31:0] / b[31:0]};
			end else if (is_signed) begin
				sa = a;
				sb = b;
				sq = is_rem ? sa % sb : sa / sb;
				r = sq;
			end else begin
				r = is_rem ? a % b : a / b;
			end
		end
		// word results sign extend bit 31
		if (w) begin
			r = {{32{r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	task automatic add_row(input string name, input funct3_t f3, input logic w,
			input xlen_t a, input xlen_t b, input xlen_t exp);
		t_name.push_back(name);
		t_f3.push_back(f3);
		t_word.push_back(w);
		t_a.push_back(a);
		t_b.push_back(b);
		t_exp.push_back(exp);
	endtask

	task automatic record_test(input string name, input logic bad);
		if (bad) begin
			fail_count++;
			$display("[FAIL] %s", name);
		end else begin
			pass_count++;
			$display("[PASS] %s", name);
		end
	endtask

	task automatic wait_ready(input string name, output logic ok);
		int cnt;
		cnt = 0;
		while (!ready && cnt < 200) begin
			@(posedge clk);
			#2;
			cnt++;
		end
		ok = ready;
		if (!ok) begin
			$display("%s: ready did not rise within 200 cycles", name);
			timed_out = 1'b1;
			fail_count++;
		end
	endtask

	// one op where stray_at > 0 drives a second op_valid that many cycles in
	task automatic run_op(input string name, input funct3_t f3, input logic w, input xlen_t a,
			input xlen_t b, input xlen_t exp, input int stray_at);
		int   lat;
		int   exp_lat;
		logic ok;
		logic bad;
		logic ready_leak;
		bad = 1'b0;
		ready_leak = 1'b0;
		exp_lat = f3[2] ? (w ? 35 : 67) : (w ? 19 : 35);
		wait_ready(name, ok);
		if (!ok) begin
			return;
		end
		funct3 = f3;
		word = w;
		src_a = a;
		src_b = b;
		op_valid = 1'b1;
		@(posedge clk);
		#2;
		op_valid = 1'b0;
		// cycles counted from the accepting edge
		lat = 0;
		while (!result_valid && lat < 200) begin
			if (ready) begin
				ready_leak = 1'b1;
			end
			if (stray_at > 0 && lat == stray_at) begin
				op_valid = 1'b1;
				funct3 = F3_MUL;
				src_a = 64'd3;
				src_b = 64'd5;
			end
			@(posedge clk);
			#2;
			op_valid = 1'b0;
			lat++;
		end
		if (!result_valid) begin
			$display("%s: no result_valid within 200 cycles", name);
			timed_out = 1'b1;
			fail_count++;
			return;
		end
		if (result !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, result);
			bad = 1'b1;
		end
		if (lat != exp_lat) begin
			$display("%s: result came after %0d cycles instead of %0d", name, lat, exp_lat);
			bad = 1'b1;
		end
		if (ready_leak) begin
			$display("%s: ready went high while the operation was running", name);
			bad = 1'b1;
		end
		if (!ready) begin
			$display("%s: ready was low in the result cycle", name);
			bad = 1'b1;
		end
		record_test(name, bad);
	endtask

	task automatic expect_no_result(input string name, input int cycles);
		int seen;
		seen = 0;
		repeat (cycles) begin
			@(posedge clk);
			#2;
			if (result_valid) begin
				seen++;
			end
		end
		if (seen != 0) begin
			$display("%s: %0d result_valid pulses where none were due", name, seen);
		end
		record_test(name, seen != 0);
	endtask

	// start an op, flush it partway, then expect silence
	task automatic flush_test(input string name, input funct3_t f3, input logic w,
			input xlen_t a, input xlen_t b);
		logic ok;
		logic bad;
		bad = 1'b0;
		wait_ready(name, ok);
		if (!ok) begin
			return;
		end
		funct3 = f3;
		word = w;
		src_a = a;
		src_b = b;
		op_valid = 1'b1;
		@(posedge clk);
		#2;
		op_valid = 1'b0;
		repeat (10) begin
			@(posedge clk);
			#2;
		end
		flush = 1'b1;
		@(posedge clk);
		#2;
		flush = 1'b0;
		if (!ready) begin
			$display("%s: ready was not high the cycle after flush", name);
			bad = 1'b1;
		end
		record_test(name, bad);
		expect_no_result({name, "_quiet"}, 100);
	endtask

	// ******************************
	// directed table
	// ******************************

	task automatic build_table();
		add_row("mul_small", F3_MUL, 0, 64'd7, 64'd6, 64'h2a);
		add_row("mul_neg", F3_MUL, 0, 64'hffff_ffff_ffff_fffd, 64'd5, 64'hffff_ffff_ffff_fff1);
		add_row("mulh_neg", F3_MULH, 0, 64'hffff_ffff_ffff_fffe, 64'd3, '1);
		add_row("mulh_min_min", F3_MULH, 0, 64'h8000_0000_0000_0000,
			64'h8000_0000_0000_0000, 64'h4000_0000_0000_0000);
		add_row("mulhsu_neg", F3_MULHSU, 0, '1, '1, '1);
		add_row("mulhsu_pos", F3_MULHSU, 0, 64'd2, '1, 64'd1);
		add_row("mulhu_ones", F3_MULHU, 0, '1, '1, 64'hffff_ffff_ffff_fffe);
		add_row("div_neg", F3_DIV, 0, 64'hffff_ffff_ffff_fff1, 64'd2, 64'hffff_ffff_ffff_fff9);
		add_row("rem_neg", F3_REM, 0, 64'hffff_ffff_ffff_fff1, 64'd2, '1);
		add_row("divu_basic", F3_DIVU, 0, 64'd100, 64'd7, 64'd14);
		add_row("remu_basic", F3_REMU, 0, 64'd100, 64'd7, 64'd2);
		// divide by zero
		add_row("div_zero", F3_DIV, 0, 64'd123, 64'd0, '1);
		add_row("divu_zero", F3_DIVU, 0, 64'd123, 64'd0, '1);
		add_row("rem_zero", F3_REM, 0, 64'd123, 64'd0, 64'd123);
		add_row("remu_zero", F3_REMU, 0, 64'd5, 64'd0, 64'd5);
		// most negative by minus one
		add_row("div_ovf", F3_DIV, 0, 64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000);
		add_row("rem_ovf", F3_REM, 0, 64'h8000_0000_0000_0000, '1, 64'd0);
		add_row("divw_ovf", F3_DIV, 1, 64'h8000_0000, 64'hffff_ffff, 64'hffff_ffff_8000_0000);
		add_row("remw_ovf", F3_REM, 1, 64'h8000_0000, 64'hffff_ffff, 64'd0);
		add_row("divw_zero", F3_DIV, 1, 64'h1234_5678_9abc_def0, 64'hffff_ffff_0000_0000, '1);
		add_row("remw_zero", F3_REM, 1, 64'h1234_5678_9abc_def0, 64'hffff_ffff_0000_0000,
			64'hffff_ffff_9abc_def0);
		add_row("divuw_zero", F3_DIVU, 1, 64'd5, 64'd0, '1);
		add_row("remuw_zero", F3_REMU, 1, 64'd5, 64'd0, 64'd5);
		// word forms with junk in the upper halves
		add_row("mulw_sext", F3_MUL, 1, 64'h1_0000, 64'h8000, 64'hffff_ffff_8000_0000);
		add_row("mulw_upper", F3_MUL, 1, 64'hdead_beef_0000_0003, 64'h1234_5678_ffff_fffe,
			64'hffff_ffff_ffff_fffa);
		add_row("divw_neg", F3_DIV, 1, 64'h1111_1111_ffff_fff1, 64'd2, 64'hffff_ffff_ffff_fff9);
		add_row("remuw_small", F3_REMU, 1, 64'hffff_fff1, 64'h10, 64'd1);
		add_row("remuw_sext", F3_REMU, 1, 64'h8000_0007, 64'hffff_ffff, 64'hffff_ffff_8000_0007);
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int          i;
		logic [31:0] r;
		funct3_t     rf3;
		logic        rw;
		xlen_t       ra;
		xlen_t       rb;
		rst = 1'b1;
		op_valid = 1'b0;
		flush = 1'b0;
		funct3 = '0;
		word = 1'b0;
		src_a = '0;
		src_b = '0;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		lcg_state = 32'h1b06_0ff4;
		build_table();
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// idle state straight out of reset
		if (!ready || result_valid) begin
			$display("reset_state: ready=%b result_valid=%b after reset", ready, result_valid);
		end
		record_test("reset_state", !ready || result_valid);

		for (i = 0; i < t_name.size() && !timed_out; i++) begin
			run_op(t_name[i], t_f3[i], t_word[i], t_a[i], t_b[i], t_exp[i], 0);
		end

		for (i = 0; i < 60 && !timed_out; i++) begin
			r = lcg_next();
			rf3 = r[2:0];
			rw = r[3];
			// only mul has a w form in the multiply group
			if (rw && !rf3[2]) begin
				rf3 = F3_MUL;
			end
			ra = {lcg_next(), lcg_next()};
			rb = {lcg_next(), lcg_next()};
			case (r[5:4])
				2'd1: rb = rb >> r[11:6];
				2'd2: rb = {60'd0, r[15:12]};
				2'd3: rb = -{60'd0, r[15:12]};
				default: rb = rb;
			endcase
			run_op($sformatf("rand_%0d", i), rf3, rw, ra, rb, ref_result(rf3, rw, ra, rb), 0);
		end

		// extra op_valid while busy is ignored
		if (!timed_out) begin
			run_op("busy_extra_valid", F3_DIVU, 0, 64'd1000, 64'd3, 64'd333, 5);
			expect_no_result("busy_no_extra", 80);
		end
		if (!timed_out) begin
			flush_test("flush_div", F3_DIV, 0, 64'hffff_ffff_ffff_fff1, 64'd2);
			run_op("after_flush_div", F3_REM, 0, 64'hffff_ffff_ffff_fff1, 64'd2, '1, 0);
		end
		if (!timed_out) begin
			flush_test("flush_mul", F3_MULHU, 0, '1, '1);
			run_op("after_flush_mul", F3_MULHU, 0, '1, '1, 64'hffff_ffff_ffff_fffe, 0);
		end

		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid,
	input  logic                flush,
	input  muldiv_pkg::funct3_t funct3,
	input  logic                word,
	input  muldiv_pkg::xlen_t   src_a,
	input  muldiv_pkg::xlen_t   src_b,
	output logic                ready,
	output logic                result_valid,
	output muldiv_pkg::xlen_t   result
);
	import muldiv_pkg::*;

	// dispatch
	logic       accept;
	logic       mul_valid;
	logic       div_valid;
	logic [1:0] mul_signed;
	logic       div_signed;

	// engine status
	logic       mul_ready;
	logic       div_ready;
	logic       mul_done;
	logic       div_done;
	logic       fmt_pending;

	// raw engine results
	xlen_t      result_hi;
	xlen_t      result_lo;
	xlen_t      quotient;
	xlen_t      remainder;

	// ******************************
	// decode and dispatch
	// ******************************

	// one op in flight, including the cycle it sits in the formatter
	assign ready  = mul_ready & div_ready & ~fmt_pending;
	assign accept = op_valid & ready;

	// funct3 bit 2 picks the divider
	assign mul_valid = accept & ~funct3[2];
	assign div_valid = accept & funct3[2];

	// bit 1 multiplicand signed, bit 0 multiplier signed
	always_comb begin
		case (funct3)
			F3_MULHSU: mul_signed = 2'b10;
			F3_MULHU:  mul_signed = 2'b00;
			default:   mul_signed = 2'b11;
		endcase
	end

	assign div_signed = (funct3 == F3_DIV) || (funct3 == F3_REM);

	// ******************************
	// engines and formatter
	// ******************************

	booth_multiplier u_mul (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (word),
		.mul_signed   (mul_signed),
		.multiplicand (src_a),
		.multiplier   (src_b),
		.mul_ready    (mul_ready),
		.out_valid    (mul_done),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	restoring_divider u_div (
		.clk        (clk),
		.rst        (rst),
		.div_valid  (div_valid),
		.flush      (flush),
		.divw       (word),
		.div_signed (div_signed),
		.dividend   (src_a),
		.divisor    (src_b),
		.div_ready  (div_ready),
		.out_valid  (div_done),
		.quotient   (quotient),
		.remainder  (remainder)
	);

	muldiv_result_format u_fmt (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.accept       (accept),
		.funct3       (funct3),
		.word         (word),
		.src_a        (src_a),
		.src_b        (src_b),
		.mul_done     (mul_done),
		.result_hi    (result_hi),
		.result_lo    (result_lo),
		.div_done     (div_done),
		.quotient     (quotient),
		.remainder    (remainder),
		.pending      (fmt_pending),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* muldiv_result_format.sv */
`timescale 1ns/1ps

module muldiv_result_format (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush,
	input  logic                accept,
	input  muldiv_pkg::funct3_t funct3,
	input  logic                word,
	input  muldiv_pkg::xlen_t   src_a,
	input  muldiv_pkg::xlen_t   src_b,
	input  logic                mul_done,
	input  muldiv_pkg::xlen_t   result_hi,
	input  muldiv_pkg::xlen_t   result_lo,
	input  logic                div_done,
	input  muldiv_pkg::xlen_t   quotient,
	input  muldiv_pkg::xlen_t   remainder,
	output logic                pending,
	output logic                result_valid,
	output muldiv_pkg::xlen_t   result
);
	import muldiv_pkg::*;

	// captured operation
	funct3_t op_q;
	logic    word_q;
	xlen_t   a_q;
	xlen_t   b_q;

	logic    engine_done;
	logic    div_zero;
	logic    div_ovf;
	word_t   a_lo;
	word_t   b_lo;
	xlen_t   raw;
	xlen_t   fmt;

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q   <= funct3;
			word_q <= word;
			a_q    <= src_a;
			b_q    <= src_b;
		end
	end

	// ******************************
	// special cases and selection
	// ******************************

	always_comb begin
		a_lo = a_q[31:0];
		b_lo = b_q[31:0];
		div_zero = word_q ? (b_lo == 32'd0) : (b_q == 64'd0);
		// signed only, most negative by minus one
		div_ovf = !op_q[0] && (word_q ?
			(a_lo == 32'h8000_0000 && b_lo == 32'hffff_ffff) :
			(a_q == 64'h8000_0000_0000_0000 && b_q == '1));
		case (op_q)
			F3_MUL:                      raw = result_lo;
			F3_MULH, F3_MULHSU, F3_MULHU: raw = result_hi;
			F3_DIV, F3_DIVU:             raw = div_zero ? '1 : (div_ovf ? a_q : quotient);
			F3_REM, F3_REMU:             raw = div_zero ? a_q : (div_ovf ? '0 : remainder);
			default:                     raw = result_lo;
		endcase
		// w ops sign extend from bit 31
		fmt = word_q ? {{32{raw[31]}}, raw[31:0]} : raw;
	end

	// only the engine that owns the op can finish it
	assign engine_done = pending && (op_q[2] ? div_done : mul_done);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pending      <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= engine_done;
			if (engine_done) begin
				pending <= 1'b0;
			end else if (accept) begin
				pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (engine_done) begin
			result <= fmt;
		end
	end

endmodule

/* restoring_divider.sv */
`timescale 1ns/1ps

module restoring_divider (
	input  logic              clk,
	input  logic              rst,
	input  logic              div_valid,
	input  logic              flush,
	input  logic              divw,
	input  logic              div_signed,
	input  muldiv_pkg::xlen_t dividend,
	input  muldiv_pkg::xlen_t divisor,
	output logic              div_ready,
	output logic              out_valid,
	output muldiv_pkg::xlen_t quotient,
	output muldiv_pkg::xlen_t remainder
);
	import muldiv_pkg::*;

	// control
	div_state_t  state;
	step_t       step_cnt;

	// payload registers
	xlen_t       quo_q;
	xlen_t       rem_q;
	xlen_t       dsor_q;
	logic        q_neg;
	logic        r_neg;

	// operand prep
	xlen_t       dend_ext;
	xlen_t       dsor_ext;
	logic        dend_neg;
	logic        dsor_neg;
	xlen_t       dend_mag;
	xlen_t       dsor_mag;

	// one shift-subtract step
	logic [64:0] rem_shift;
	logic [64:0] trial;

	// word ops take the low half, sign or zero extended
	function automatic xlen_t extend_op(input xlen_t val, input logic sgn, input logic w);
		word_t lo;
		lo = val[31:0];
		if (!w) begin
			extend_op = val;
		end else if (sgn) begin
			extend_op = {{32{lo[31]}}, lo};
		end else begin
			extend_op = {32'd0, lo};
		end
	endfunction

	// ******************************
	// magnitudes and result signs
	// ******************************

	always_comb begin
		dend_ext = extend_op(dividend, div_signed, divw);
		dsor_ext = extend_op(divisor, div_signed, divw);
		dend_neg = div_signed & dend_ext[63];
		dsor_neg = div_signed & dsor_ext[63];
		dend_mag = dend_neg ? -dend_ext : dend_ext;
		dsor_mag = dsor_neg ? -dsor_ext : dsor_ext;
	end

	// next dividend bit comes off the top of quo_q
	always_comb begin
		rem_shift = {rem_q, quo_q[63]};
		trial     = rem_shift - {1'b0, dsor_q};
	end

	// ******************************
	// sequencing
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= DIV_IDLE;
			step_cnt  <= '0;
			out_valid <= 1'b0;
		end else if (flush) begin
			state     <= DIV_IDLE;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				DIV_IDLE: begin
					if (div_valid) begin
						state    <= DIV_RUN;
						step_cnt <= divw ? DIV_STEPS_W : DIV_STEPS_D;
					end
				end
				DIV_RUN: begin
					step_cnt <= step_cnt - 7'd1;
					if (step_cnt == 7'd1) begin
						state <= DIV_FIX;
					end
				end
				// sign fix-up takes its own cycle
				DIV_FIX:  state <= DIV_DONE;
				DIV_DONE: begin
					out_valid <= 1'b1;
					state     <= DIV_IDLE;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			DIV_IDLE: begin
				if (div_valid) begin
					// word dividend goes in the top half so bit 63 shifts out first
					quo_q  <= divw ? {dend_mag[31:0], 32'd0} : dend_mag;
					rem_q  <= '0;
					dsor_q <= dsor_mag;
					q_neg  <= dend_neg ^ dsor_neg;
					r_neg  <= dend_neg;
				end
			end
			DIV_RUN: begin
				// keep the difference when it did not go negative
				if (!trial[64]) begin
					rem_q <= trial[63:0];
					quo_q <= {quo_q[62:0], 1'b1};
				end else begin
					rem_q <= rem_shift[63:0];
					quo_q <= {quo_q[62:0], 1'b0};
				end
			end
			DIV_FIX: begin
				// truncating division, remainder follows the dividend
				if (q_neg) begin
					quo_q <= -quo_q;
				end
				if (r_neg) begin
					rem_q <= -rem_q;
				end
			end
			default: begin
				quo_q <= quo_q;
			end
		endcase
	end

	assign div_ready = (state == DIV_IDLE);
	assign quotient  = quo_q;
	assign remainder = rem_q;

endmodule

/* booth_multiplier.sv */
`timescale 1ns/1ps

module booth_multiplier (
	input  logic              clk,
	input  logic              rst,
	input  logic              mul_valid,
	input  logic              flush,
	input  logic              mulw,
	input  logic [1:0]        mul_signed,
	input  muldiv_pkg::xlen_t multiplicand,
	input  muldiv_pkg::xlen_t multiplier,
	output logic              mul_ready,
	output logic              out_valid,
	output muldiv_pkg::xlen_t result_hi,
	output muldiv_pkg::xlen_t result_lo
);
	import muldiv_pkg::*;

	// control
	mul_state_t   state;
	step_t        step_cnt;

	// payload
	logic         mulw_q;
	logic [65:0]  mcand_q;
	logic [131:0] acc;
	logic         booth_prev;

	// step datapath
	logic [65:0]  mcand_ext;
	logic [65:0]  mplier_ext;
	logic [67:0]  mcand_68;
	logic [67:0]  part_prod;
	logic [67:0]  part_sum;
	logic [133:0] acc_wide;

	// 66-bit extension by signedness or from bit 31 for word ops
	function automatic logic [65:0] extend_66(input xlen_t val, input logic sgn, input logic w);
		word_t lo;
		lo = val[31:0];
		if (w) begin
			extend_66 = {{34{lo[31]}}, lo};
		end else begin
			extend_66 = {{2{sgn & val[63]}}, val};
		end
	endfunction

	assign mcand_ext  = extend_66(multiplicand, mul_signed[1], mulw);
	assign mplier_ext = extend_66(multiplier, mul_signed[0], mulw);

	// ******************************
	// one radix-4 booth step
	// ******************************

	always_comb begin
		// two guard bits so +-2M plus the running sum never wraps
		mcand_68 = {{2{mcand_q[65]}}, mcand_q};
		// recode multiplier bits {i+1, i, i-1}
		case ({acc[1:0], booth_prev})
			3'b001, 3'b010: part_prod = mcand_68;
			3'b011:         part_prod = mcand_68 << 1;
			3'b100:         part_prod = -(mcand_68 << 1);
			3'b101, 3'b110: part_prod = -mcand_68;
			default:        part_prod = '0;
		endcase
		part_sum = {{2{acc[131]}}, acc[131:66]} + part_prod;
		// arithmetic shift by two happens in the slice [133:2]
		acc_wide = {part_sum, acc[65:0]};
	end

	// ******************************
	// sequencing
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= MUL_IDLE;
			step_cnt  <= '0;
			out_valid <= 1'b0;
		end else if (flush) begin
			// abort drops the result
			state     <= MUL_IDLE;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				MUL_IDLE: begin
					if (mul_valid) begin
						state    <= MUL_RUN;
						step_cnt <= mulw ? MUL_STEPS_W : MUL_STEPS_D;
					end
				end
				MUL_RUN: begin
					step_cnt <= step_cnt - 7'd1;
					// last step this edge
					if (step_cnt == 7'd1) begin
						state <= MUL_DONE;
					end
				end
				MUL_DONE: begin
					out_valid <= 1'b1;
					state     <= MUL_IDLE;
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	// accumulator holds {partial sum, remaining multiplier bits}
	always_ff @(posedge clk) begin
		if (state == MUL_IDLE && mul_valid) begin
			mcand_q    <= mcand_ext;
			acc        <= {66'd0, mplier_ext};
			booth_prev <= 1'b0;
			mulw_q     <= mulw;
		end else if (state == MUL_RUN) begin
			acc        <= acc_wide[133:2];
			booth_prev <= acc[1];
		end
	end

	assign mul_ready = (state == MUL_IDLE);

	// word run stops after 34 bits so the product starts at acc[32]
	assign result_lo = mulw_q ? acc[95:32] : acc[63:0];
	assign result_hi = mulw_q ? {64{acc[131]}} : acc[127:64];

endmodule

/* muldiv_pkg.sv */
package muldiv_pkg;

	// ******************************
	// data widths
	// ******************************

	// operand and result width, xlen fixed at 64
	typedef logic [63:0] xlen_t;

	// low half used by the w-suffixed ops
	typedef logic [31:0] word_t;

	// m-extension minor opcode
	typedef logic [2:0] funct3_t;

	// engine step counter, wide enough for 64
	typedef logic [6:0] step_t;

	// ******************************
	// funct3 codes
	// ******************************

	// multiply group, bit 2 clear
	localparam funct3_t F3_MUL    = 3'd0;
	localparam funct3_t F3_MULH   = 3'd1;
	localparam funct3_t F3_MULHSU = 3'd2;
	localparam funct3_t F3_MULHU  = 3'd3;

	// divide group, bit 2 set
	localparam funct3_t F3_DIV    = 3'd4;
	localparam funct3_t F3_DIVU   = 3'd5;
	localparam funct3_t F3_REM    = 3'd6;
	localparam funct3_t F3_REMU   = 3'd7;

	// ******************************
	// iteration counts
	// ******************************

	// radix-4 booth retires two multiplier bits per step
	// 66-bit extended operand gives 33, 34-bit word operand gives 17
	localparam step_t MUL_STEPS_D = 7'd33;
	localparam step_t MUL_STEPS_W = 7'd17;

	// restoring divider retires one quotient bit per step
	localparam step_t DIV_STEPS_D = 7'd64;
	localparam step_t DIV_STEPS_W = 7'd32;

	// engine state machines
	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIX,
		DIV_DONE
	} div_state_t;

endpackage
